// ==== vlog.f ====
verilog/addsub_pkg.sv
verilog/bk_adder_16.sv
verilog/addsub_32.sv
verilog/apb_addsub_regs.sv
verilog/apb_addsub_top.sv
tests/apb_addsub_assertions.sv
tests/apb_addsub_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the apb add/sub testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
   -f vlog.f \
   --top-module apb_addsub_tb \
   -o apb_addsub_sim

./obj_dir/apb_addsub_sim 2>&1 | tee sim.log

if grep -q "Testbench failed" sim.log; then
   echo "simulation reported a failure, see sim.log"
   exit 1
fi

echo "simulation finished without failures"

// ==== tests/apb_addsub_tb.sv ====
// apb add/sub testbench
`timescale 1ns/1ps

module apb_addsub_tb import addsub_pkg::*; ();

   localparam int reset_cycles = 16;
   localparam int xfer_cycles  = 3;    // setup, access, idle
   localparam int row_xfers    = 7;
   localparam int extra_xfers  = 24;
   localparam int random_rows  = 16;

   logic              clk;
   logic              rst;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [addr_w-1:0] paddr;
   logic [data_w-1:0] pwdata;
   logic [data_w-1:0] prdata;
   logic              pready;
   logic              pslverr;

   int errors;
   int checks;
   int timeout_limit;
   int cycle_count;

   // stimulus table with one entry per row
   logic [data_w-1:0] tab_a[$];
   logic [data_w-1:0] tab_b[$];
   logic              tab_sub[$];
   logic              tab_cin[$];
   logic [data_w-1:0] tab_res[$];
   logic [flag_w-1:0] tab_flags[$];

   apb_addsub_top apb_addsub_top_inst (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
         errors++;
      end
   endtask

   task automatic apb_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                            output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      check_value("pready", {31'b0, pready}, 32'h1);   // zero wait states
      err = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
                           output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      check_value("pready", {31'b0, pready}, 32'h1);   // zero wait states
      data = prdata;                     // registered and stable since last rise
      err  = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_ok(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
      logic err;
      apb_write(addr, data, err);
      check_value("pslverr", {31'b0, err}, 32'h0);
   endtask

   task automatic read_expect(input logic [addr_w-1:0] addr, input string name,
                              input logic [data_w-1:0] exp);
      logic [data_w-1:0] data;
      logic              err;
      apb_read(addr, data, err);
      check_value(name, data, exp);
      check_value("pslverr", {31'b0, err}, 32'h0);
   endtask

   // reference model in borrow form for subtraction
   function automatic logic [flag_w+data_w-1:0] expected_of(input logic [31:0] a,
         input logic [31:0] b, input logic sub, input logic cin);
      logic [32:0]       wide;
      logic [31:0]       res;
      logic              v;
      logic [flag_w-1:0] f;
      if (sub) begin
         wide = {1'b0, a} - {1'b0, b} - {32'b0, cin};
         res  = wide[31:0];
         v    = (a[31] != b[31]) && (res[31] != a[31]);
      end else begin
         wide = {1'b0, a} + {1'b0, b} + {32'b0, cin};
         res  = wide[31:0];
         v    = (a[31] == b[31]) && (res[31] != a[31]);
      end
      f             = '0;
      f[flag_carry] = sub ? ~wide[32] : wide[32];   // carry means no borrow
      f[flag_ovf]   = v;
      f[flag_zero]  = (res == 32'h0);
      f[flag_neg]   = res[31];
      return {f, res};
   endfunction

   task automatic add_row(input logic [31:0] a, input logic [31:0] b, input logic sub,
                          input logic cin, input logic [31:0] res,
                          input logic [flag_w-1:0] flags);
      tab_a.push_back(a);
      tab_b.push_back(b);
      tab_sub.push_back(sub);
      tab_cin.push_back(cin);
      tab_res.push_back(res);
      tab_flags.push_back(flags);
   endtask

   task automatic build_table();
      logic [31:0]              a;
      logic [31:0]              b;
      logic [31:0]              rnd;
      logic [flag_w+data_w-1:0] exp;
      add_row(32'hFFFF_FFFF, 32'h1, 1'b0, 1'b0, 32'h0, 4'h5);
      add_row(32'h7FFF_FFFF, 32'h1, 1'b0, 1'b0, 32'h8000_0000, 4'hA);
      add_row(32'h5, 32'h5, 1'b1, 1'b0, 32'h0, 4'h5);
      add_row(32'h0, 32'h1, 1'b1, 1'b1, 32'hFFFF_FFFE, 4'h8);
      add_row(32'h0000_FFFF, 32'h1, 1'b0, 1'b0, 32'h0001_0000, 4'h0);   // slice boundary
      add_row(32'h0000_FFFF, 32'h0, 1'b0, 1'b1, 32'h0001_0000, 4'h0);
      add_row(32'h0001_0000, 32'h1, 1'b1, 1'b0, 32'h0000_FFFF, 4'h1);
      add_row(32'h8000_0000, 32'h1, 1'b1, 1'b0, 32'h7FFF_FFFF, 4'h3);
      for (int i = 0; i < random_rows; i++) begin
         a   = $urandom;
         b   = $urandom;
         rnd = $urandom;
         exp = expected_of(a, b, rnd[0], rnd[1]);
         add_row(a, b, rnd[0], rnd[1], exp[data_w-1:0], exp[flag_w+data_w-1:data_w]);
      end
   endtask

   // watchdog
   initial begin
      cycle_count = 0;
      @(posedge clk);
      while (cycle_count < timeout_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout after %0d cycles, the test sequence did not complete", cycle_count);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      logic [data_w-1:0] ctrl_word;
      logic [data_w-1:0] held_res;
      logic [flag_w-1:0] held_flags;
      logic [data_w-1:0] data;
      logic              err;
      errors  = 0;
      checks  = 0;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      void'($urandom(55428));
      build_table();
      timeout_limit = 4 * (reset_cycles +
                           (tab_a.size() * row_xfers + extra_xfers) * xfer_cycles);

      repeat (reset_cycles) @(negedge clk);
      rst = 1'b0;

      read_expect(reg_op_a, "prdata(op_a)", 32'h0);
      read_expect(reg_op_b, "prdata(op_b)", 32'h0);
      read_expect(reg_result, "prdata(result)", 32'h0);
      read_expect(reg_flags, "prdata(flags)", 32'h0);   // zero flag clear too

      foreach (tab_a[i]) begin
         write_ok(reg_op_a, tab_a[i]);
         write_ok(reg_op_b, tab_b[i]);
         read_expect(reg_op_a, "prdata(op_a)", tab_a[i]);
         read_expect(reg_op_b, "prdata(op_b)", tab_b[i]);
         ctrl_word               = '0;
         ctrl_word[ctrl_sub_bit] = tab_sub[i];
         ctrl_word[ctrl_cin_bit] = tab_cin[i];
         write_ok(reg_ctrl, ctrl_word);
         read_expect(reg_result, "prdata(result)", tab_res[i]);
         read_expect(reg_flags, "prdata(flags)", {28'h0, tab_flags[i]});
      end

      // operands rewritten without a ctrl write
      held_res   = tab_res[tab_res.size()-1];
      held_flags = tab_flags[tab_flags.size()-1];
      read_expect(reg_ctrl, "prdata(ctrl)", 32'h0);
      write_ok(reg_op_a, 32'h1234_5678);
      write_ok(reg_op_b, 32'h0F0F_0F0F);
      read_expect(reg_result, "prdata(result)", held_res);
      read_expect(reg_flags, "prdata(flags)", {28'h0, held_flags});

      // error responses
      apb_read(5'h14, data, err);
      check_value("pslverr", {31'b0, err}, 32'h1);
      apb_read(5'h18, data, err);
      check_value("pslverr", {31'b0, err}, 32'h1);
      apb_read(5'h1C, data, err);
      check_value("pslverr", {31'b0, err}, 32'h1);
      apb_read(5'h02, data, err);
      check_value("pslverr", {31'b0, err}, 32'h1);
      apb_write(reg_result, 32'hDEAD_BEEF, err);
      check_value("pslverr", {31'b0, err}, 32'h1);
      apb_write(reg_flags, 32'h0000_000F, err);
      check_value("pslverr", {31'b0, err}, 32'h1);
      apb_write(5'h14, 32'hFFFF_FFFF, err);
      check_value("pslverr", {31'b0, err}, 32'h1);
      read_expect(reg_result, "prdata(result)", held_res);
      read_expect(reg_flags, "prdata(flags)", {28'h0, held_flags});
      read_expect(reg_op_a, "prdata(op_a)", 32'h1234_5678);
      read_expect(reg_op_b, "prdata(op_b)", 32'h0F0F_0F0F);

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== tests/apb_addsub_assertions.sv ====
// apb add/sub protocol assertions
`timescale 1ns/1ps

module apb_addsub_assertions import addsub_pkg::*; (
   input logic              clk,
   input logic              rst,
   input logic              psel,
   input logic              penable,
   input logic              pslverr,
   input logic              ctrl_wr,
   input logic [data_w-1:0] result_q
);

   assert property (@(posedge clk) disable iff (rst) penable |-> psel)
      else $error("penable high without psel");

   // error response only while the access phase is on the bus
   assert property (@(posedge clk) disable iff (rst) !(psel && penable) |-> !pslverr)
      else $error("pslverr high outside an access phase");

   assert property (@(posedge clk) disable iff (rst) !$stable(result_q) |-> $past(ctrl_wr))
      else $error("result register changed without a ctrl write");

endmodule

bind apb_addsub_regs apb_addsub_assertions assertions_inst (
   .clk      (clk),
   .rst      (rst),
   .psel     (psel),
   .penable  (penable),
   .pslverr  (pslverr),
   .ctrl_wr  (ctrl_wr),
   .result_q (result_q)
);

// ==== verilog/apb_addsub_top.sv ====
// apb add/sub peripheral top
`timescale 1ns/1ps

module apb_addsub_top import addsub_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [addr_w-1:0] paddr,
   input  logic [data_w-1:0] pwdata,
   output logic [data_w-1:0] prdata,
   output logic              pready,
   output logic              pslverr
);

   logic [data_w-1:0] op_a;
   logic [data_w-1:0] op_b;
   logic              sub;
   logic              cin;
   logic [data_w-1:0] sum;
   logic              carry;
   logic              ovf;
   logic              zero;
   logic              neg;

   apb_addsub_regs regs_inst (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .op_a    (op_a),
      .op_b    (op_b),
      .sub     (sub),
      .cin     (cin),
      .sum     (sum),
      .carry   (carry),
      .ovf     (ovf),
      .zero    (zero),
      .neg     (neg)
   );

   addsub_32 core_inst (
      .op_a  (op_a),
      .op_b  (op_b),
      .sub   (sub),
      .cin   (cin),
      .sum   (sum),
      .carry (carry),
      .ovf   (ovf),
      .zero  (zero),
      .neg   (neg)
   );

endmodule

// ==== verilog/apb_addsub_regs.sv ====
// apb register block for add/sub
`timescale 1ns/1ps

module apb_addsub_regs import addsub_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   // apb slave
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [addr_w-1:0] paddr,
   input  logic [data_w-1:0] pwdata,
   output logic [data_w-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   // to core
   output logic [data_w-1:0] op_a,
   output logic [data_w-1:0] op_b,
   output logic              sub,
   output logic              cin,
   // from core
   input  logic [data_w-1:0] sum,
   input  logic              carry,
   input  logic              ovf,
   input  logic              zero,
   input  logic              neg
);

   logic              setup;       // first cycle of a transfer
   logic              wr_en;       // write in access phase
   logic              ctrl_wr;
   logic              mapped;
   logic              dec_err;
   logic [data_w-1:0] rd_mux;
   logic [data_w-1:0] result_q;
   logic [flag_w-1:0] flags_q;

   assign setup   = psel & ~penable;
   assign wr_en   = psel & penable & pwrite;
   assign ctrl_wr = wr_en && (paddr == reg_ctrl);

   assign pready = 1'b1;   // no wait states

   // operation select only during the control write
   assign sub = ctrl_wr & pwdata[ctrl_sub_bit];
   assign cin = ctrl_wr & pwdata[ctrl_cin_bit];

   assign mapped = (paddr == reg_op_a)   || (paddr == reg_op_b)  ||
                   (paddr == reg_ctrl)   || (paddr == reg_result) ||
                   (paddr == reg_flags);

   // result and flags are read-only
   assign dec_err = ~mapped ||
                    (pwrite && ((paddr == reg_result) || (paddr == reg_flags)));

   always_comb begin
      case (paddr)
         reg_op_a:   rd_mux = op_a;
         reg_op_b:   rd_mux = op_b;
         reg_result: rd_mux = result_q;
         reg_flags:  rd_mux = {{(data_w-flag_w){1'b0}}, flags_q};
         default:    rd_mux = '0;        // ctrl and unmapped
      endcase
   end

   // operand registers
   always_ff @(posedge clk) begin
      if (rst) begin
         op_a <= '0;
         op_b <= '0;
      end else if (wr_en) begin
         if (paddr == reg_op_a) op_a <= pwdata;
         if (paddr == reg_op_b) op_b <= pwdata;
      end
   end

   // result latch, closes with the ctrl write
   always_ff @(posedge clk) begin
      if (rst) begin
         result_q <= '0;
         flags_q  <= '0;
      end else if (ctrl_wr) begin
         result_q            <= sum;
         flags_q[flag_carry] <= carry;
         flags_q[flag_ovf]   <= ovf;
         flags_q[flag_zero]  <= zero;
         flags_q[flag_neg]   <= neg;
      end
   end

   // response sampled in setup, held for the access phase
   always_ff @(posedge clk) begin
      if (rst) begin
         prdata  <= '0;
         pslverr <= 1'b0;
      end else if (setup) begin
         prdata  <= pwrite ? '0 : rd_mux;
         pslverr <= dec_err;
      end else begin
         prdata  <= '0;
         pslverr <= 1'b0;
      end
   end

endmodule

// ==== verilog/addsub_32.sv ====
// 32-bit add/subtract core
`timescale 1ns/1ps

module addsub_32 import addsub_pkg::*; (
   input  logic [data_w-1:0] op_a,
   input  logic [data_w-1:0] op_b,
   input  logic              sub,
   input  logic              cin,
   output logic [data_w-1:0] sum,
   output logic              carry,
   output logic              ovf,
   output logic              zero,
   output logic              neg
);

   logic [data_w-1:0] b_eff;   // op_b after optional inversion
   logic              c_in0;   // carry into bit 0
   logic              c_mid;   // lo slice to hi slice

   assign b_eff = sub ? ~op_b : op_b;
   assign c_in0 = sub ? ~cin : cin;   // borrow becomes inverted carry

   bk_adder_16 slice_lo (
      .a    (op_a[slice_w-1:0]),
      .b    (b_eff[slice_w-1:0]),
      .cin  (c_in0),
      .sum  (sum[slice_w-1:0]),
      .cout (c_mid)
   );

   bk_adder_16 slice_hi (
      .a    (op_a[data_w-1:slice_w]),
      .b    (b_eff[data_w-1:slice_w]),
      .cin  (c_mid),
      .sum  (sum[data_w-1:slice_w]),
      .cout (carry)                  // no borrow when subtracting
   );

   // signed overflow, like signs in and a different sign out
   assign ovf = (op_a[data_w-1] == b_eff[data_w-1]) &&
                (sum[data_w-1] != op_a[data_w-1]);

   assign zero = ~|sum;
   assign neg  = sum[data_w-1];

endmodule

// ==== verilog/bk_adder_16.sv ====
// brent-kung 16-bit adder
`timescale 1ns/1ps

module bk_adder_16 import addsub_pkg::*; (
   input  logic [slice_w-1:0] a,
   input  logic [slice_w-1:0] b,
   input  logic               cin,
   output logic [slice_w-1:0] sum,
   output logic               cout
);

   logic [slice_w-1:0] p;      // bit propagate
   logic [slice_w-1:0] g;      // bit generate
   logic [slice_w-1:0] g_c;    // generate with cin folded into bit 0

   // up-sweep group terms, index k covers a span of 2, 4, 8 bits
   logic [7:0] l1_g;
   logic [7:1] l1_p;           // span 1:0 propagate never needed
   logic [3:0] l2_g;
   logic [3:1] l2_p;
   logic [1:0] l3_g;
   logic       l3_p_hi;        // span 15:8
   logic       l4_g;           // span 15:0

   // co[i] is carry out of bit i, i.e. group generate i:0
   logic [slice_w-1:0] co;

   genvar k;

   assign p = a ^ b;
   assign g = a & b;

   assign g_c[slice_w-1:1] = g[slice_w-1:1];
   assign g_c[0]           = g[0] | (p[0] & cin);

   // level 1, pairs
   generate
      for (k = 0; k < 8; k = k + 1) begin : gen_l1_g
         assign l1_g[k] = g_c[2*k+1] | (p[2*k+1] & g_c[2*k]);
      end
      for (k = 1; k < 8; k = k + 1) begin : gen_l1_p
         assign l1_p[k] = p[2*k+1] & p[2*k];
      end
   endgenerate

   // level 2, nibbles
   generate
      for (k = 0; k < 4; k = k + 1) begin : gen_l2_g
         assign l2_g[k] = l1_g[2*k+1] | (l1_p[2*k+1] & l1_g[2*k]);
      end
      for (k = 1; k < 4; k = k + 1) begin : gen_l2_p
         assign l2_p[k] = l1_p[2*k+1] & l1_p[2*k];
      end
   endgenerate

   // level 3, bytes
   assign l3_g[0] = l2_g[1] | (l2_p[1] & l2_g[0]);
   assign l3_g[1] = l2_g[3] | (l2_p[3] & l2_g[2]);
   assign l3_p_hi = l2_p[3] & l2_p[2];

   // level 4, whole slice
   assign l4_g = l3_g[1] | (l3_p_hi & l3_g[0]);

   // carries straight from the up-sweep
   assign co[0]  = g_c[0];
   assign co[1]  = l1_g[0];
   assign co[3]  = l2_g[0];
   assign co[7]  = l3_g[0];
   assign co[15] = l4_g;

   // down-sweep, odd positions
   assign co[11] = l2_g[2] | (l2_p[2] & co[7]);
   assign co[5]  = l1_g[2] | (l1_p[2] & co[3]);
   assign co[9]  = l1_g[4] | (l1_p[4] & co[7]);
   assign co[13] = l1_g[6] | (l1_p[6] & co[11]);

   // even positions need one more cell each
   generate
      for (k = 1; k < 8; k = k + 1) begin : gen_even_c
         assign co[2*k] = g[2*k] | (p[2*k] & co[2*k-1]);
      end
   endgenerate

   assign sum  = p ^ {co[slice_w-2:0], cin};
   assign cout = co[slice_w-1];

endmodule

// ==== verilog/addsub_pkg.sv ====
// add/sub peripheral definitions
package addsub_pkg;

   // datapath widths
   localparam int data_w  = 32;
   localparam int slice_w = 16;   // one prefix adder slice
   localparam int addr_w  = 5;

   // register map, byte offsets
   localparam logic [addr_w-1:0] reg_op_a   = 5'h00;   // rw
   localparam logic [addr_w-1:0] reg_op_b   = 5'h04;   // rw
   localparam logic [addr_w-1:0] reg_ctrl   = 5'h08;   // wo, reads zero
   localparam logic [addr_w-1:0] reg_result = 5'h0C;   // ro
   localparam logic [addr_w-1:0] reg_flags  = 5'h10;   // ro

   // control word bits
   localparam int ctrl_sub_bit = 0;   // 1 = subtract
   localparam int ctrl_cin_bit = 1;   // carry for add, borrow for sub

   // flag register bits
   localparam int flag_carry = 0;
   localparam int flag_ovf   = 1;
   localparam int flag_zero  = 2;
   localparam int flag_neg   = 3;
   localparam int flag_w     = 4;

endpackage
